//--- tag_lookup.f
+incdir+include
hw/tag_lookup_pkg.sv
hw/tag_req_arbiter.sv
hw/tag_hash_bank.sv
hw/tag_result_merge.sv
hw/tag_table_host.sv
hw/tag_lookup_top.sv
tests/tag_lookup_checker.sv
tests/tag_lookup_monitor.sv
tests/tag_lookup_tb.sv

//--- Bender.yml
package:
  name: tag_lookup

export_include_dirs:
  - include

sources:
  - hw/tag_lookup_pkg.sv
  - hw/tag_req_arbiter.sv
  - hw/tag_hash_bank.sv
  - hw/tag_result_merge.sv
  - hw/tag_table_host.sv
  - hw/tag_lookup_top.sv
  - target: test
    files:
      - tests/tag_lookup_checker.sv
      - tests/tag_lookup_monitor.sv
      - tests/tag_lookup_tb.sv

//--- tests/tag_lookup_tb.sv
//*********************************************************************
// Tag lookup engine testbench: programs the tables over Wishbone and
// drives PU lookups, alone and with all four PUs contending
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_lookup_tb
	import tag_lookup_pkg::*;
();

	localparam int          WAIT_LIMIT = 200;
	localparam int          VALUES     = 1 << `VALUE_AW;
	localparam int          NUM_KEYS   = 12;
	localparam logic [31:0] LFSR_SEED  = 32'hd08ecef0;

	logic               clk;
	logic               rst_n;
	logic [`NUM_PU-1:0] req;
	tag_key_t           key [`NUM_PU];
	wire  [`NUM_PU-1:0] ack;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic [`WB_AW-1:0]  wb_adr;
	logic [`WB_DW-1:0]  wb_dat_w;
	wire  [`WB_DW-1:0]  wb_dat_r;
	wire                wb_ack;
	wire lookup_result_t result;

	logic [31:0] lfsr_state;
	tag_key_t    next_key [`NUM_PU];
	tag_key_t    hit_keys [NUM_KEYS];
	tag_value_t  value_written [VALUES];
	int          tb_errors;
	int          expected_results;
	int          mon_errors;
	int          mon_results;
	int          mon_hits;
	int          mon_misses;

	tag_lookup_top DUT (.*);

	tag_lookup_monitor u_monitor (
		.*, .err_count(mon_errors), .result_count(mon_results),
		.hit_count(mon_hits), .miss_count(mon_misses)
	);

	always #50 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic bucket_idx_t hashed_index(input tag_key_t k, input tag_key_t salt);
		tag_key_t x;
		x = k ^ salt;
		return x[5:0] ^ x[11:6] ^ {2'b00, x[15:12]};
	endfunction

	task automatic wb_access(input logic we, input logic [`WB_AW-1:0] adr,
	                         input logic [`WB_DW-1:0] wdata, output logic [`WB_DW-1:0] rdata);
		int waited;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		waited   = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < WAIT_LIMIT);
		if (!wb_ack) begin
			tb_errors++;
			$display("Wishbone access to address %h was never acknowledged", adr);
		end
		rdata = wb_dat_r;
		@(negedge clk);    // Hold the strobe through the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] data);
		logic [`WB_DW-1:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic check_read(input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] expected,
	                          input string name);
		logic [`WB_DW-1:0] got;
		wb_access(1'b0, adr, '0, got);
		if (got !== expected) begin
			tb_errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, expected, got);
		end
	endtask

	task automatic place_entry(input int bank, input tag_key_t k, input value_idx_t vidx);
		logic [`WB_AW-1:0] adr;
		adr = (bank == 0) ? `BANK0_BASE + hashed_index(k, `TAG_SALT0)
		                  : `BANK1_BASE + hashed_index(k, `TAG_SALT1);
		wb_write(adr, {8'h00, 1'b1, k, vidx});
		check_read(adr, '0, "wb_dat_r");    // no bucket read-back
	endtask

	// Pulse req for the PUs in mask and collect one ack from each
	task automatic launch(input logic [`NUM_PU-1:0] mask);
		int   ack_seen [`NUM_PU];
		int   waited;
		logic done;
		@(negedge clk);
		for (int i = 0; i < `NUM_PU; i++) begin
			key[i] = next_key[i];
			ack_seen[i] = 0;
		end
		req = mask;
		@(negedge clk);
		req = '0;
		waited = 0;
		done = 1'b0;
		while (!done && waited < WAIT_LIMIT) begin
			done = 1'b1;
			for (int i = 0; i < `NUM_PU; i++) begin
				if (ack[i])
					ack_seen[i]++;
				if (mask[i] && ack_seen[i] == 0)
					done = 1'b0;
			end
			if (!done) begin
				@(negedge clk);
				waited++;
			end
		end
		for (int i = 0; i < `NUM_PU; i++) begin
			if (mask[i] && ack_seen[i] == 0) begin
				tb_errors++;
				$display("PU %0d request was never acknowledged", i);
			end
		end
		expected_results += $countones(mask);
	endtask

	task automatic wait_results();
		int waited;
		waited = 0;
		while (mon_results < expected_results && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (mon_results < expected_results) begin
			tb_errors++;
			$display("Only %0d of %0d lookup results arrived", mon_results, expected_results);
		end
	endtask

	initial begin
		logic [31:0] w;
		logic [31:0] v;
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		for (int i = 0; i < `NUM_PU; i++) begin
			key[i] = '0;
			next_key[i] = '0;
		end
		lfsr_state = LFSR_SEED;
		tb_errors = 0;
		expected_results = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < VALUES; i++) begin
			take_bits(32, w);
			value_written[i] = w;
			wb_write(`VALUE_BASE + i, w);
		end
		for (int i = 0; i < VALUES; i++)
			check_read(`VALUE_BASE + i, value_written[i], "wb_dat_r");

		// Keys 0-3 in bank 0 only, 4-7 in bank 1 only, 8-11 in both
		for (int i = 0; i < NUM_KEYS; i++) begin
			take_bits(16, w);
			take_bits(7, v);
			place_entry((i < 8) ? i / 4 : 0, w[15:0], v[6:0]);
			if (i >= 8) begin
				take_bits(7, v);
				place_entry(1, w[15:0], v[6:0]);
			end
			hit_keys[i] = w[15:0];
			next_key[i % `NUM_PU] = w[15:0];
			launch(`NUM_PU'(1) << (i % `NUM_PU));
			wait_results();
		end

		// Unprogrammed keys, then keys sharing a bucket with a stored key
		for (int i = 0; i < 8; i++) begin
			take_bits(16, w);
			next_key[i % `NUM_PU] = (i < 4) ? w[15:0] : hit_keys[i] ^ 16'h0041;
			launch(`NUM_PU'(1) << (i % `NUM_PU));
		end
		wait_results();

		for (int round = 0; round < 10; round++) begin
			for (int p = 0; p < `NUM_PU; p++) begin
				take_bits(5, w);
				if (round == 0)
					next_key[p] = hit_keys[p];
				else if (w[4])
					next_key[p] = hit_keys[w[3:0] % NUM_KEYS];
				else begin
					take_bits(16, w);
					next_key[p] = w[15:0];
				end
			end
			launch('1);
		end
		wait_results();

		check_read(`HIT_CNT_ADDR, mon_hits, "hit_cnt");
		check_read(`MISS_CNT_ADDR, mon_misses, "miss_cnt");
		wb_write(`HIT_CNT_ADDR, '0);
		wb_write(`MISS_CNT_ADDR, '0);
		check_read(`HIT_CNT_ADDR, '0, "hit_cnt");
		check_read(`MISS_CNT_ADDR, '0, "miss_cnt");

		$display("Errors: %0d testbench, %0d monitor, %0d assertion",
		         tb_errors, mon_errors, DUT.u_checker.fail_count);
		if (tb_errors == 0 && mon_errors == 0 && DUT.u_checker.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tag_lookup_monitor.sv
//*********************************************************************
// Lookup monitor that models both banks and the value memory from
// host writes and checks every result against a reference lookup
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_lookup_monitor
	import tag_lookup_pkg::*;
(
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire [`NUM_PU-1:0]   req,
	input  wire tag_key_t       key [`NUM_PU],
	input  wire [`NUM_PU-1:0]   ack,
	input  wire                 wb_cyc,
	input  wire                 wb_stb,
	input  wire                 wb_we,
	input  wire [`WB_AW-1:0]    wb_adr,
	input  wire [`WB_DW-1:0]    wb_dat_w,
	input  wire                 wb_ack,
	input  wire lookup_result_t result,
	output int                  err_count,
	output int                  result_count,
	output int                  hit_count,
	output int                  miss_count
);

	localparam int BUCKETS = 1 << `BUCKET_AW;
	localparam int VALUES  = 1 << `VALUE_AW;

	bucket_entry_t      bank_model [2][BUCKETS];
	tag_value_t         value_model [VALUES];
	tag_key_t           req_key [`NUM_PU];      // Key of the request still pending
	tag_key_t           flight_key [`NUM_PU];   // Key of the acked lookup
	logic [`NUM_PU-1:0] req_open;               // Request seen, ack still due
	pu_id_t             grant_order [$];        // Acked PUs, oldest first

	function automatic bucket_idx_t bucket_of(input tag_key_t k, input tag_key_t salt);
		tag_key_t x;
		x = k ^ salt;
		return x[5:0] ^ x[11:6] ^ {2'b00, x[15:12]};
	endfunction

	// Bank 0 wins when both banks hold the key
	function automatic lookup_result_t ref_lookup(input tag_key_t k, input pu_id_t pid);
		bucket_entry_t  e0;
		bucket_entry_t  e1;
		logic           h0;
		logic           h1;
		lookup_result_t r;
		e0 = bank_model[0][bucket_of(k, `TAG_SALT0)];
		e1 = bank_model[1][bucket_of(k, `TAG_SALT1)];
		h0 = e0.valid && (e0.key == k);
		h1 = e1.valid && (e1.key == k);
		r = '0;
		r.valid = 1'b1;
		r.pid = pid;
		r.status = h0 ? (h1 ? `ST_DUAL : `ST_HIT0) : (h1 ? `ST_HIT1 : `ST_MISS);
		if (h0)
			r.value = value_model[e0.vidx];
		else if (h1)
			r.value = value_model[e1.vidx];
		return r;
	endfunction

	initial begin
		for (int i = 0; i < BUCKETS; i++) begin
			bank_model[0][i] = '0;
			bank_model[1][i] = '0;
		end
		for (int i = 0; i < VALUES; i++)
			value_model[i] = '0;
		req_open     = '0;
		err_count    = 0;
		result_count = 0;
		hit_count    = 0;
		miss_count   = 0;
	end

	always @(posedge clk) begin
		lookup_result_t exp_r;
		pu_id_t         pid;
		if (rst_n && result.valid) begin
			result_count++;
			if (grant_order.size() == 0) begin
				err_count++;
				$display("A lookup result arrived with no acknowledged request");
			end else begin
				pid   = grant_order.pop_front();
				exp_r = ref_lookup(flight_key[pid], pid);
				if (exp_r.status == `ST_MISS)
					miss_count++;
				else
					hit_count++;
				if (result.pid !== exp_r.pid) begin
					err_count++;
					$display("error at %0t: result.pid expected %0d got %0d",
					         $time, exp_r.pid, result.pid);
				end
				if (result.status !== exp_r.status) begin
					err_count++;
					$display("error at %0t: result.status expected %0d got %0d",
					         $time, exp_r.status, result.status);
				end
				if (result.value !== exp_r.value) begin
					err_count++;
					$display("error at %0t: result.value expected %h got %h",
					         $time, exp_r.value, result.value);
				end
			end
		end
		if (rst_n) begin
			for (int i = 0; i < `NUM_PU; i++) begin
				if (ack[i]) begin
					if (!req_open[i]) begin
						err_count++;
						$display("PU %0d was acknowledged with no request outstanding", i);
					end
					req_open[i]   = 1'b0;
					flight_key[i] = req_key[i];
					grant_order.push_back(pu_id_t'(i));
				end
				if (req[i]) begin
					req_key[i]  = key[i];
					req_open[i] = 1'b1;
				end
			end
			// Host writes commit on the acknowledge edge
			if (wb_cyc && wb_stb && wb_we && wb_ack) begin
				if (wb_adr < `BANK1_BASE)
					bank_model[0][wb_adr[`BUCKET_AW-1:0]] = bucket_entry_t'(wb_dat_w[23:0]);
				else if (wb_adr < `VALUE_BASE)
					bank_model[1][wb_adr[`BUCKET_AW-1:0]] = bucket_entry_t'(wb_dat_w[23:0]);
				else if (wb_adr < `HIT_CNT_ADDR)
					value_model[wb_adr[`VALUE_AW-1:0]] = wb_dat_w;
				else if (wb_adr == `HIT_CNT_ADDR)
					hit_count = 0;
				else if (wb_adr == `MISS_CNT_ADDR)
					miss_count = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tag_lookup_checker.sv
//*********************************************************************
// Handshake and pipeline assertions bound into the lookup top level
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_lookup_checker (
	input wire               clk,
	input wire               rst_n,
	input wire [`NUM_PU-1:0] ack,
	input wire               wb_ack,
	input wire               grant,
	input wire               result_valid
);

	int fail_count;

	initial fail_count = 0;

	wb_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else begin
			fail_count++;
			$error("wb_ack stayed high for more than one cycle");
		end

	ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ack))
		else begin
			fail_count++;
			$error("more than one PU acknowledged in the same cycle");
		end

	// Two pipeline stages behind the grant
	grant_to_result: assert property (@(posedge clk) disable iff (!rst_n)
		grant |-> ##2 result_valid)
		else begin
			fail_count++;
			$error("no result two cycles after a grant");
		end

	result_from_grant: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> $past(grant, 2))
		else begin
			fail_count++;
			$error("result appeared without a grant two cycles earlier");
		end

endmodule

bind tag_lookup_top tag_lookup_checker u_checker (
	.clk(clk), .rst_n(rst_n), .ack(ack), .wb_ack(wb_ack),
	.grant(lookup_req.valid), .result_valid(result.valid)
);

`default_nettype wire

//--- hw/tag_lookup_top.sv
//*********************************************************************
// Tag lookup engine top: PU arbiter, two salted hash banks, result
// merge and the Wishbone table port
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_lookup_top
	import tag_lookup_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire [`NUM_PU-1:0]  req,
	input  wire tag_key_t      key [`NUM_PU],
	output wire [`NUM_PU-1:0]  ack,
	input  wire                wb_cyc,
	input  wire                wb_stb,
	input  wire                wb_we,
	input  wire [`WB_AW-1:0]   wb_adr,
	input  wire [`WB_DW-1:0]   wb_dat_w,
	output wire [`WB_DW-1:0]   wb_dat_r,
	output wire                wb_ack,
	output lookup_result_t     result
);

	wire tag_req_t      lookup_req;
	wire bank_verdict_t verdict0;
	wire bank_verdict_t verdict1;
	wire                bank0_wr;
	wire                bank1_wr;
	wire bucket_idx_t   bucket_idx;
	wire bucket_entry_t entry;
	wire                val_wr_en;
	wire value_idx_t    val_idx;
	wire tag_value_t    val_wdata;
	wire tag_value_t    rd_value;
	wire [1:0]          cnt_clr;
	wire [`WB_DW-1:0]   hit_cnt;
	wire [`WB_DW-1:0]   miss_cnt;

	tag_req_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n),
		.req(req), .key(key), .ack(ack),
		.lookup_req(lookup_req)
	);

	tag_hash_bank #(.SALT(`TAG_SALT0)) u_bank0 (
		.clk(clk), .rst_n(rst_n), .lookup_req(lookup_req),
		.wr_en(bank0_wr), .wr_idx(bucket_idx), .wr_entry(entry),
		.verdict(verdict0)
	);

	tag_hash_bank #(.SALT(`TAG_SALT1)) u_bank1 (
		.clk(clk), .rst_n(rst_n), .lookup_req(lookup_req),
		.wr_en(bank1_wr), .wr_idx(bucket_idx), .wr_entry(entry),
		.verdict(verdict1)
	);

	tag_result_merge u_merge (
		.clk(clk), .rst_n(rst_n),
		.verdict0(verdict0), .verdict1(verdict1),
		.val_wr_en(val_wr_en), .val_idx(val_idx), .val_wdata(val_wdata),
		.cnt_clr(cnt_clr), .rd_value(rd_value),
		.hit_cnt(hit_cnt), .miss_cnt(miss_cnt),
		.result(result)
	);

	tag_table_host u_host (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.bank0_wr(bank0_wr), .bank1_wr(bank1_wr),
		.bucket_idx(bucket_idx), .entry(entry),
		.val_wr_en(val_wr_en), .val_idx(val_idx), .val_wdata(val_wdata),
		.cnt_clr(cnt_clr), .rd_value(rd_value),
		.hit_cnt(hit_cnt), .miss_cnt(miss_cnt)
	);

endmodule

`default_nettype wire

//--- hw/tag_table_host.sv
//*********************************************************************
// Wishbone classic slave for the table contents: writes banks and
// value memory, reads values and the statistics counters
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_table_host
	import tag_lookup_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire                wb_cyc,
	input  wire                wb_stb,
	input  wire                wb_we,
	input  wire [`WB_AW-1:0]   wb_adr,
	input  wire [`WB_DW-1:0]   wb_dat_w,
	output logic [`WB_DW-1:0]  wb_dat_r,
	output logic               wb_ack,
	output logic               bank0_wr,
	output logic               bank1_wr,
	output bucket_idx_t        bucket_idx,
	output bucket_entry_t      entry,
	output logic               val_wr_en,
	output value_idx_t         val_idx,
	output tag_value_t         val_wdata,
	output logic [1:0]         cnt_clr,
	input  wire tag_value_t    rd_value,
	input  wire [`WB_DW-1:0]   hit_cnt,
	input  wire [`WB_DW-1:0]   miss_cnt
);

	host_state_e       state;
	logic              is_bank0;
	logic              is_bank1;
	logic              is_value;
	logic              is_hit_cnt;
	logic              is_miss_cnt;
	logic              wr_cycle;
	logic [`WB_DW-1:0] rd_data;

	// Address decode
	assign is_bank0    = wb_adr < `BANK1_BASE;
	assign is_bank1    = (wb_adr >= `BANK1_BASE) && (wb_adr < `VALUE_BASE);
	assign is_value    = (wb_adr >= `VALUE_BASE) && (wb_adr < `HIT_CNT_ADDR);
	assign is_hit_cnt  = wb_adr == `HIT_CNT_ADDR;
	assign is_miss_cnt = wb_adr == `MISS_CNT_ADDR;

	// Writes commit on the acknowledge edge
	assign wr_cycle = (state == ACK) && wb_cyc && wb_stb && wb_we;
	assign wb_ack   = state == ACK;

	assign bank0_wr   = wr_cycle && is_bank0;
	assign bank1_wr   = wr_cycle && is_bank1;
	assign val_wr_en  = wr_cycle && is_value;
	assign cnt_clr    = {wr_cycle && is_miss_cnt, wr_cycle && is_hit_cnt};

	assign bucket_idx = wb_adr[`BUCKET_AW-1:0];
	assign entry      = bucket_entry_t'(wb_dat_w[$bits(bucket_entry_t)-1:0]);
	assign val_idx    = wb_adr[`VALUE_AW-1:0];
	assign val_wdata  = wb_dat_w;

	always_comb begin
		rd_data = '0;    // Bucket regions and holes read zero
		if (is_value)
			rd_data = rd_value;
		else if (is_hit_cnt)
			rd_data = hit_cnt;
		else if (is_miss_cnt)
			rd_data = miss_cnt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (wb_cyc && wb_stb) state <= ACK;
				ACK:     state <= IDLE;    // Master drops stb after ack
				default: state <= IDLE;
			endcase
		end
	end

	// Read data sampled with the strobe, presented during ack
	always_ff @(posedge clk) begin
		if (state == IDLE && wb_cyc && wb_stb)
			wb_dat_r <= rd_data;
	end

endmodule

`default_nettype wire

//--- hw/tag_result_merge.sv
//*********************************************************************
// Result merge: combines both bank verdicts, reads the value memory
// and keeps the hit and miss statistics
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_result_merge
	import tag_lookup_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire bank_verdict_t verdict0,
	input  wire bank_verdict_t verdict1,
	input  wire                val_wr_en,
	input  wire value_idx_t    val_idx,
	input  wire tag_value_t    val_wdata,
	input  wire [1:0]          cnt_clr,    // [0] hits, [1] misses
	output tag_value_t         rd_value,
	output logic [`WB_DW-1:0]  hit_cnt,
	output logic [`WB_DW-1:0]  miss_cnt,
	output lookup_result_t     result
);

	localparam int VAL_DEPTH = 1 << `VALUE_AW;

	tag_value_t     val_mem [VAL_DEPTH];
	logic           hit0;
	logic           hit1;
	lookup_status_t status;
	value_idx_t     sel_idx;
	tag_value_t     hit_value;

	assign hit0    = verdict0.valid && verdict0.hit;
	assign hit1    = verdict1.valid && verdict1.hit;
	assign sel_idx = hit0 ? verdict0.vidx : verdict1.vidx;    // bank 0 wins

	always_comb begin
		case ({hit1, hit0})
			2'b01:   status = `ST_HIT0;
			2'b10:   status = `ST_HIT1;
			2'b11:   status = `ST_DUAL;
			default: status = `ST_MISS;
		endcase
	end

	assign hit_value = (hit0 || hit1) ? val_mem[sel_idx] : '0;
	assign rd_value  = val_mem[val_idx];    // Host read-back

	always_ff @(posedge clk) begin
		if (val_wr_en)
			val_mem[val_idx] <= val_wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result   <= '0;
			hit_cnt  <= '0;
			miss_cnt <= '0;
		end else begin
			result <= '{valid: verdict0.valid, status: status,
			            value: hit_value, pid: verdict0.pid};
			if (cnt_clr[0])
				hit_cnt <= '0;
			else if (verdict0.valid && status != `ST_MISS)
				hit_cnt <= hit_cnt + 1'b1;
			if (cnt_clr[1])
				miss_cnt <= '0;
			else if (verdict0.valid && status == `ST_MISS)
				miss_cnt <= miss_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/tag_hash_bank.sv
//*********************************************************************
// Salted hash bank: 64-entry bucket table with host write port and a
// registered key compare per lookup
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_hash_bank
	import tag_lookup_pkg::*;
#(
	parameter logic [`TAG_KEY_W-1:0] SALT = `TAG_SALT0
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire tag_req_t      lookup_req,
	input  wire                wr_en,
	input  wire bucket_idx_t   wr_idx,
	input  wire bucket_entry_t wr_entry,
	output bank_verdict_t      verdict
);

	localparam int DEPTH = 1 << `BUCKET_AW;

	logic [DEPTH-1:0] ent_valid;    // Cleared on reset, so all buckets start invalid
	tag_key_t         ent_key [DEPTH];
	value_idx_t       ent_vidx [DEPTH];
	bucket_idx_t      rd_idx;
	logic             rd_hit;

	// Fold salted key into 6-bit groups
	function automatic bucket_idx_t tag_hash(input tag_key_t k);
		tag_key_t x;
		x = k ^ SALT;
		return x[5:0] ^ x[11:6] ^ {2'b00, x[15:12]};
	endfunction

	assign rd_idx = tag_hash(lookup_req.key);
	assign rd_hit = ent_valid[rd_idx] && (ent_key[rd_idx] == lookup_req.key);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ent_valid <= '0;
			verdict   <= '0;
		end else begin
			if (wr_en)
				ent_valid[wr_idx] <= wr_entry.valid;
			verdict <= '{valid: lookup_req.valid,
			             hit:   lookup_req.valid && rd_hit,
			             vidx:  ent_vidx[rd_idx],
			             pid:   lookup_req.pid};
		end
	end

	// Same-edge write leaves the registered verdict with the old entry
	always_ff @(posedge clk) begin
		if (wr_en) begin
			ent_key[wr_idx]  <= wr_entry.key;
			ent_vidx[wr_idx] <= wr_entry.vidx;
		end
	end

endmodule

`default_nettype wire

//--- hw/tag_req_arbiter.sv
//*********************************************************************
// PU request arbiter: one pending slot per PU, round-robin grant of
// one lookup per cycle with a one-cycle acknowledge
//*********************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "tag_lookup_params.svh"

module tag_req_arbiter
	import tag_lookup_pkg::*;
(
	input  wire                clk,
	input  wire                rst_n,
	input  wire [`NUM_PU-1:0]  req,
	input  wire tag_key_t      key [`NUM_PU],
	output logic [`NUM_PU-1:0] ack,
	output tag_req_t           lookup_req
);

	logic [`NUM_PU-1:0] pending;
	tag_key_t           key_q [`NUM_PU];
	pu_id_t             rr_ptr;    // First PU to consider
	pu_id_t             cand;
	pu_id_t             gnt_id;
	logic               gnt_found;
	logic [`NUM_PU-1:0] gnt_vec;

	// Lowest pending PU at or after the pointer
	always_comb begin
		gnt_found = 1'b0;
		gnt_id    = rr_ptr;
		cand      = rr_ptr;
		for (int off = 0; off < `NUM_PU; off++) begin
			cand = rr_ptr + pu_id_t'(off);    // wraps at NUM_PU
			if (!gnt_found && pending[cand]) begin
				gnt_found = 1'b1;
				gnt_id    = cand;
			end
		end
	end

	assign gnt_vec = gnt_found ? (`NUM_PU'(1) << gnt_id) : '0;

	assign lookup_req = '{valid: gnt_found, key: key_q[gnt_id], pid: gnt_id};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			rr_ptr  <= '0;
			ack     <= '0;
		end else begin
			// A new request may land on the cycle its old grant clears
			pending <= (pending & ~gnt_vec) | req;
			ack     <= gnt_vec;
			if (gnt_found)
				rr_ptr <= gnt_id + pu_id_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `NUM_PU; i++) begin
			if (req[i])
				key_q[i] <= key[i];
		end
	end

endmodule

`default_nettype wire

//--- hw/tag_lookup_pkg.sv
//*********************************************************************
// Tag lookup types: key, index and value vectors, pipeline structs
// and the host port state machine encoding
//*********************************************************************
`default_nettype none

`include "tag_lookup_params.svh"

package tag_lookup_pkg;

	typedef logic [`TAG_KEY_W-1:0]       tag_key_t;
	typedef logic [$clog2(`NUM_PU)-1:0]  pu_id_t;
	typedef logic [`BUCKET_AW-1:0]       bucket_idx_t;
	typedef logic [`VALUE_AW-1:0]        value_idx_t;
	typedef logic [`TAG_VALUE_W-1:0]     tag_value_t;
	typedef logic [1:0]                  lookup_status_t;

	// Host writes this as data bits 23..0
	typedef struct packed {
		logic       valid;
		tag_key_t   key;
		value_idx_t vidx;
	} bucket_entry_t;

	typedef struct packed {
		logic     valid;
		tag_key_t key;
		pu_id_t   pid;
	} tag_req_t;

	typedef struct packed {
		logic       valid;
		logic       hit;
		value_idx_t vidx;
		pu_id_t     pid;
	} bank_verdict_t;

	typedef struct packed {
		logic           valid;
		lookup_status_t status;
		tag_value_t     value;
		pu_id_t         pid;
	} lookup_result_t;

	typedef enum logic {IDLE, ACK} host_state_e;

endpackage

`default_nettype wire

//--- include/tag_lookup_params.svh
//*********************************************************************
// Tag lookup engine parameters: widths, depths, salts, host address
// map and lookup status codes
//*********************************************************************
`ifndef TAG_LOOKUP_PARAMS_SVH
`define TAG_LOOKUP_PARAMS_SVH

`define NUM_PU        4
`define TAG_KEY_W     16
`define BUCKET_AW     6        // 64 buckets per bank
`define VALUE_AW      7        // 128 values
`define TAG_VALUE_W   32
`define WB_AW         9
`define WB_DW         32

`define TAG_SALT0     16'h5a3c
`define TAG_SALT1     16'hc3a5

// Host address map
`define BANK0_BASE    9'h000
`define BANK1_BASE    9'h040
`define VALUE_BASE    9'h080
`define HIT_CNT_ADDR  9'h100
`define MISS_CNT_ADDR 9'h101

`define ST_MISS       2'd0
`define ST_HIT0       2'd1
`define ST_HIT1       2'd2
`define ST_DUAL       2'd3

`endif
